// File: common/vm16_pkg.sv
// shared types, instruction encodings and parameter defaults for the vm16 core
// every design file refers to these by scoped name
package vm16_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [4:0]  funct_t;

    // opcode lives in instr[15:11]
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h07,
        OP_HALT    = 5'h1f
    } opcode_t;

    // function codes inside the BIT and ARITH_U groups
    localparam funct_t FN_OR     = 5'h00;
    localparam funct_t FN_XOR    = 5'h01;
    localparam funct_t FN_AND    = 5'h02;
    localparam funct_t FN_NOT    = 5'h03;
    localparam funct_t FN_LSHIFT = 5'h04;
    localparam funct_t FN_RSHIFT = 5'h05;
    localparam funct_t FN_ADD    = 5'h1f;
    localparam funct_t FN_SUB    = 5'h10;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_PASS_B,
        ALU_OR,
        ALU_XOR,
        ALU_AND,
        ALU_NOT,
        ALU_LSHIFT,
        ALU_RSHIFT,
        ALU_ADD,
        ALU_SUB,
        ALU_BAD
    } alu_op_t;

    typedef struct packed {
        reg_sel_t rd;
        reg_sel_t ra;
        word_t    imm;
        funct_t   offset;
        alu_op_t  alu_op;
        logic     has_imm;
        logic     writes_reg;
        logic     is_mem;
        logic     is_store;
        logic     is_halt;
    } dec_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_LOAD,
        S_READ_RD,
        S_READ_RA,
        S_MEM,
        S_WRITE_BACK,
        S_HALTED
    } core_state_t;

    localparam int INSTR_DEPTH_DEFAULT   = 64;
    localparam int SCRATCH_DEPTH_DEFAULT = 64;

endpackage

// File: common/vm16_mem_if.sv
// request/done link from the core sequencer to the memory unit
// one request outstanding at a time, rdata valid while done is high
`timescale 1ns/1ps

interface vm16_mem_if;

    logic            req;
    logic            we;
    vm16_pkg::word_t addr;
    vm16_pkg::word_t wdata;
    vm16_pkg::word_t rdata;
    logic            done;

    // sequencer side
    modport master (
        output req, we, addr, wdata,
        input  rdata, done
    );

    // memory unit side
    modport slave (
        input  req, we, addr, wdata,
        output rdata, done
    );

endinterface

// File: design/vm16_bram.sv
// single port synchronous block memory, one cycle read latency
// payload type is chosen per instance
`timescale 1ns/1ps

module vm16_bram #(
    parameter int  DEPTH     = 64,
    parameter type payload_t = logic [15:0]
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // output register keeps its value through a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: core/vm16_decoder.sv
// instruction decoder, purely combinational
// splits the fields out and derives the ALU op and control flags
`timescale 1ns/1ps

module vm16_decoder (
    input  vm16_pkg::instr_t instr,
    output vm16_pkg::dec_t   dec
);

    vm16_pkg::opcode_t opcode;

    assign opcode = vm16_pkg::opcode_t'(instr[15:11]);

    always_comb begin
        dec        = '0;
        dec.rd     = instr[10:8];
        dec.ra     = instr[7:5];
        dec.imm    = {8'h00, instr[7:0]};
        dec.offset = instr[4:0];
        dec.alu_op = vm16_pkg::ALU_NOP;

        case (opcode)
            vm16_pkg::OP_HALT: dec.is_halt = 1'b1;
            vm16_pkg::OP_LW: begin
                dec.alu_op     = vm16_pkg::ALU_PASS_B;
                dec.is_mem     = 1'b1;
                dec.writes_reg = 1'b1;
            end
            vm16_pkg::OP_SW: begin
                dec.alu_op   = vm16_pkg::ALU_PASS_B;
                dec.is_mem   = 1'b1;
                dec.is_store = 1'b1;
            end
            vm16_pkg::OP_MOV, vm16_pkg::OP_MOVI: begin
                dec.alu_op     = vm16_pkg::ALU_PASS_B;
                dec.writes_reg = 1'b1;
                dec.has_imm    = (opcode == vm16_pkg::OP_MOVI);
            end
            vm16_pkg::OP_BIT: begin
                dec.writes_reg = 1'b1;
                case (dec.offset)
                    vm16_pkg::FN_OR:     dec.alu_op = vm16_pkg::ALU_OR;
                    vm16_pkg::FN_XOR:    dec.alu_op = vm16_pkg::ALU_XOR;
                    vm16_pkg::FN_AND:    dec.alu_op = vm16_pkg::ALU_AND;
                    vm16_pkg::FN_NOT:    dec.alu_op = vm16_pkg::ALU_NOT;
                    vm16_pkg::FN_LSHIFT: dec.alu_op = vm16_pkg::ALU_LSHIFT;
                    vm16_pkg::FN_RSHIFT: dec.alu_op = vm16_pkg::ALU_RSHIFT;
                    default:             dec.alu_op = vm16_pkg::ALU_BAD;
                endcase
            end
            vm16_pkg::OP_ARITH_U: begin
                dec.writes_reg = 1'b1;
                case (dec.offset)
                    vm16_pkg::FN_ADD: dec.alu_op = vm16_pkg::ALU_ADD;
                    vm16_pkg::FN_SUB: dec.alu_op = vm16_pkg::ALU_SUB;
                    default:          dec.alu_op = vm16_pkg::ALU_BAD;
                endcase
            end
            // NOP and anything unknown fall through with no flags set
            default: dec.alu_op = vm16_pkg::ALU_NOP;
        endcase
    end

endmodule

// File: core/vm16_alu.sv
// combinational ALU, a is the rd operand and b the ra operand or immediate
`timescale 1ns/1ps

module vm16_alu (
    input  vm16_pkg::alu_op_t op,
    input  vm16_pkg::word_t   a,
    input  vm16_pkg::word_t   b,
    output vm16_pkg::word_t   c
);

    always_comb begin
        case (op)
            // moves and load/store addresses
            vm16_pkg::ALU_PASS_B: c = b;

            vm16_pkg::ALU_OR:     c = a | b;
            vm16_pkg::ALU_XOR:    c = a ^ b;
            vm16_pkg::ALU_AND:    c = a & b;
            vm16_pkg::ALU_NOT:    c = ~b;
            vm16_pkg::ALU_LSHIFT: c = a << b;
            vm16_pkg::ALU_RSHIFT: c = a >> b;

            // wraps at 16 bits
            vm16_pkg::ALU_ADD:    c = a + b;
            vm16_pkg::ALU_SUB:    c = a - b;

            // NOP and BAD
            default:              c = '0;
        endcase
    end

endmodule

// File: core/vm16_regfile.sv
// eight general registers, one combinational read port and one write port
// register n comes out of reset holding n
`timescale 1ns/1ps

module vm16_regfile (
    input  logic               clk,
    input  logic               reset,
    input  vm16_pkg::reg_sel_t rd_sel,
    input  logic               we,
    input  vm16_pkg::reg_sel_t wr_sel,
    input  vm16_pkg::word_t    wdata,
    output vm16_pkg::word_t    rd_data
);

    vm16_pkg::word_t regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= vm16_pkg::word_t'(i);
            end
        end else if (we) begin
            regs[wr_sel] <= wdata;
        end
    end

    assign rd_data = regs[rd_sel];

endmodule

// File: core/vm16_pc.sv
// program counter, steps by one and stops at the last instruction address
`timescale 1ns/1ps

module vm16_pc #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,
    input  logic                     halt,
    output logic [$clog2(DEPTH)-1:0] pc
);

    localparam int ADDR_W = $clog2(DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (step && !halt && pc != ADDR_W'(DEPTH - 1)) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

// File: core/vm16_control.sv
// instruction sequencer, one instruction at a time through fetch, read, mem, write back
// holds the instruction register and both operand registers
`timescale 1ns/1ps

module vm16_control (
    input  logic               clk,
    input  logic               reset,
    input  vm16_pkg::instr_t   mem_out,
    input  vm16_pkg::dec_t     dec,
    input  vm16_pkg::word_t    rd_data,
    input  vm16_pkg::word_t    alu_out,
    output vm16_pkg::instr_t   instr,
    output vm16_pkg::reg_sel_t rd_sel,
    output vm16_pkg::word_t    operand_a,
    output vm16_pkg::word_t    operand_b,
    output logic               pc_step,
    output logic               reg_we,
    output vm16_pkg::word_t    reg_wdata,
    output logic               halted,
    vm16_mem_if.master         mem
);

    vm16_pkg::core_state_t state;
    vm16_pkg::word_t       load_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= vm16_pkg::S_FETCH;
            instr   <= '0;
            mem.req <= 1'b0;
        end else begin
            mem.req <= 1'b0;
            case (state)
                vm16_pkg::S_FETCH: state <= vm16_pkg::S_LOAD;
                vm16_pkg::S_LOAD: begin
                    instr <= mem_out;
                    state <= vm16_pkg::S_READ_RD;
                end
                vm16_pkg::S_READ_RD: state <= vm16_pkg::S_READ_RA;
                vm16_pkg::S_READ_RA: begin
                    if (dec.is_mem) begin
                        state   <= vm16_pkg::S_MEM;
                        mem.req <= 1'b1;
                    end else begin
                        state <= vm16_pkg::S_WRITE_BACK;
                    end
                end
                vm16_pkg::S_MEM: begin
                    if (mem.done) begin
                        state <= vm16_pkg::S_WRITE_BACK;
                    end
                end
                vm16_pkg::S_WRITE_BACK: begin
                    state <= dec.is_halt ? vm16_pkg::S_HALTED : vm16_pkg::S_FETCH;
                end
                vm16_pkg::S_HALTED: state <= vm16_pkg::S_HALTED;
                default: state <= vm16_pkg::S_FETCH;
            endcase
        end
    end

    // operands and load data
    always_ff @(posedge clk) begin
        if (state == vm16_pkg::S_READ_RD) begin
            operand_a <= rd_data;
        end
        if (state == vm16_pkg::S_READ_RA) begin
            operand_b <= dec.has_imm ? dec.imm : rd_data;
        end
        if (state == vm16_pkg::S_MEM && mem.done) begin
            load_data <= mem.rdata;
        end
    end

    // single read port shared between rd and ra
    assign rd_sel = (state == vm16_pkg::S_READ_RD) ? dec.rd : dec.ra;

    assign pc_step   = (state == vm16_pkg::S_LOAD);
    assign halted    = (state == vm16_pkg::S_HALTED);
    assign reg_we    = dec.writes_reg && (state == vm16_pkg::S_WRITE_BACK);
    assign reg_wdata = dec.is_mem ? load_data : alu_out;

    // base register passes through the ALU, offset added here
    assign mem.addr  = alu_out + vm16_pkg::word_t'(dec.offset);
    assign mem.we    = dec.is_store;
    assign mem.wdata = operand_a;

    a_req_on_mem_entry: assert property (@(posedge clk) disable iff (reset)
        mem.req |-> state == vm16_pkg::S_MEM && $past(state) == vm16_pkg::S_READ_RA);

    // a load writes back right after done, anything else right after the operand read
    a_we_in_write_back: assert property (@(posedge clk) disable iff (reset)
        reg_we |-> (dec.is_mem ? $past(mem.done) : $past(state) == vm16_pkg::S_READ_RA));

endmodule

// File: mmu/vm16_mmu.sv
// memory unit, low addresses hit the local scratch memory
// everything else becomes a single APB master transfer
`timescale 1ns/1ps

module vm16_mmu #(
    parameter int SCRATCH_DEPTH = 64
) (
    input  logic            clk,
    input  logic            reset,
    vm16_mem_if.slave       mem,
    output vm16_pkg::word_t paddr,
    output logic            pwrite,
    output logic            psel,
    output logic            penable,
    output vm16_pkg::word_t pwdata,
    input  vm16_pkg::word_t prdata,
    input  logic            pready
);

    localparam int SCRATCH_AW = $clog2(SCRATCH_DEPTH);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    apb_state_t      apb_state;
    logic            scratch_hit;
    logic            scratch_we;
    logic            scratch_done;
    logic            apb_done;
    vm16_pkg::word_t scratch_rdata;
    vm16_pkg::word_t apb_rdata;

    assign scratch_hit = mem.addr < vm16_pkg::word_t'(SCRATCH_DEPTH);
    assign scratch_we  = mem.req && scratch_hit && mem.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            apb_state    <= APB_IDLE;
            pwrite       <= 1'b0;
            scratch_done <= 1'b0;
            apb_done     <= 1'b0;
        end else begin
            // scratch answers one cycle after the request
            scratch_done <= mem.req && scratch_hit;
            apb_done     <= 1'b0;
            case (apb_state)
                APB_IDLE: begin
                    if (mem.req && !scratch_hit) begin
                        apb_state <= APB_SETUP;
                        pwrite    <= mem.we;
                    end
                end
                APB_SETUP: apb_state <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready) begin
                        apb_state <= APB_IDLE;
                        apb_done  <= 1'b1;
                    end
                end
                default: apb_state <= APB_IDLE;
            endcase
        end
    end

    // transfer address, write data and read capture
    always_ff @(posedge clk) begin
        if (mem.req && !scratch_hit) begin
            paddr  <= mem.addr;
            pwdata <= mem.wdata;
        end
        if (apb_state == APB_ACCESS && pready) begin
            apb_rdata <= prdata;
        end
    end

    assign psel    = (apb_state != APB_IDLE);
    assign penable = (apb_state == APB_ACCESS);

    assign mem.done  = scratch_done || apb_done;
    assign mem.rdata = scratch_done ? scratch_rdata : apb_rdata;

    vm16_bram #(.DEPTH(SCRATCH_DEPTH), .payload_t(vm16_pkg::word_t)) u_scratch (
        .clk(clk), .addr(mem.addr[SCRATCH_AW-1:0]), .we(scratch_we),
        .wdata(mem.wdata), .rdata(scratch_rdata)
    );

    // an access cycle follows a setup cycle and the transfer fields hold meanwhile
    a_enable_after_setup: assert property (@(posedge clk) disable iff (reset)
        penable |-> $past(psel) && $stable(paddr) && $stable(pwdata) && $stable(pwrite));

    a_no_bus_for_scratch: assert property (@(posedge clk) disable iff (reset)
        mem.req && scratch_hit |=> !psel);

endmodule

// File: core/vm16_core.sv
// vm16 core top, sequencer, datapath, instruction memory and memory unit
// the instruction memory is loaded through the prog ports while reset is high
`timescale 1ns/1ps

module vm16_core #(
    parameter int INSTR_DEPTH   = vm16_pkg::INSTR_DEPTH_DEFAULT,
    parameter int SCRATCH_DEPTH = vm16_pkg::SCRATCH_DEPTH_DEFAULT
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_we,
    input  logic [$clog2(INSTR_DEPTH)-1:0] prog_addr,
    input  vm16_pkg::instr_t               prog_data,
    output vm16_pkg::word_t                paddr,
    output logic                           pwrite,
    output logic                           psel,
    output logic                           penable,
    output vm16_pkg::word_t                pwdata,
    input  vm16_pkg::word_t                prdata,
    input  logic                           pready,
    output logic [$clog2(INSTR_DEPTH)-1:0] pc,
    output logic                           halted
);

    logic [$clog2(INSTR_DEPTH)-1:0] imem_addr;
    vm16_pkg::instr_t               imem_rdata;
    vm16_pkg::instr_t               instr;
    vm16_pkg::dec_t                 dec;
    vm16_pkg::reg_sel_t             rd_sel;
    vm16_pkg::word_t                rd_data;
    vm16_pkg::word_t                operand_a;
    vm16_pkg::word_t                operand_b;
    vm16_pkg::word_t                alu_out;
    vm16_pkg::word_t                reg_wdata;
    logic                           pc_step;
    logic                           reg_we;

    vm16_mem_if mem_bus ();

    // loader owns the address while it writes
    assign imem_addr = prog_we ? prog_addr : pc;

    vm16_control u_control (
        .clk(clk), .reset(reset),
        .mem_out(imem_rdata), .dec(dec), .rd_data(rd_data), .alu_out(alu_out),
        .instr(instr), .rd_sel(rd_sel), .operand_a(operand_a), .operand_b(operand_b),
        .pc_step(pc_step), .reg_we(reg_we), .reg_wdata(reg_wdata), .halted(halted),
        .mem(mem_bus.master)
    );

    vm16_pc #(.DEPTH(INSTR_DEPTH)) u_pc (
        .clk(clk), .reset(reset), .step(pc_step), .halt(halted), .pc(pc)
    );

    vm16_bram #(.DEPTH(INSTR_DEPTH), .payload_t(vm16_pkg::instr_t)) u_imem (
        .clk(clk), .addr(imem_addr), .we(prog_we), .wdata(prog_data), .rdata(imem_rdata)
    );

    vm16_decoder u_decoder (.instr(instr), .dec(dec));

    vm16_regfile u_regfile (
        .clk(clk), .reset(reset), .rd_sel(rd_sel),
        .we(reg_we), .wr_sel(dec.rd), .wdata(reg_wdata), .rd_data(rd_data)
    );

    vm16_alu u_alu (.op(dec.alu_op), .a(operand_a), .b(operand_b), .c(alu_out));

    vm16_mmu #(.SCRATCH_DEPTH(SCRATCH_DEPTH)) u_mmu (
        .clk(clk), .reset(reset), .mem(mem_bus.slave),
        .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable), .pwdata(pwdata),
        .prdata(prdata), .pready(pready)
    );

endmodule

// File: sim/tb_apb_slave.sv
// APB slave model for the core testbench
// logs writes in a queue and answers reads from a preloaded map after wait states
`timescale 1ns/1ps

module tb_apb_slave (
    input  logic            clk,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  vm16_pkg::word_t paddr,
    input  vm16_pkg::word_t pwdata,
    input  logic [1:0]      wait_states,
    output vm16_pkg::word_t prdata,
    output logic            pready
);

    vm16_pkg::word_t read_map [256];
    vm16_pkg::word_t write_addr_q [$];
    vm16_pkg::word_t write_data_q [$];
    int              wait_left;

    initial begin
        pready    = 1'b0;
        prdata    = '0;
        wait_left = 0;
        // default read contents, different at every map address
        for (int i = 0; i < 256; i++) begin
            read_map[i] = 16'h5a00 ^ {8'(i), 8'(i)};
        end
    end

    always @(posedge clk) begin
        if (psel && !penable) begin
            // setup cycle, wait count fixed for this transfer
            wait_left = wait_states;
            #1;
            pready = (wait_left == 0);
            prdata = read_map[paddr[7:0]];
        end else if (psel && penable && !pready) begin
            wait_left = wait_left - 1;
            #1;
            pready = (wait_left == 0);
        end else if (psel && penable && pready) begin
            if (pwrite) begin
                write_addr_q.push_back(paddr);
                write_data_q.push_back(pwdata);
            end
            #1;
            pready = 1'b0;
        end
    end

    task automatic set_read_word(input vm16_pkg::word_t addr, input vm16_pkg::word_t data);
        read_map[addr[7:0]] = data;
    endtask

    function automatic int write_count();
        return write_addr_q.size();
    endfunction

    task automatic pop_write(output vm16_pkg::word_t addr, output vm16_pkg::word_t data);
        addr = write_addr_q.pop_front();
        data = write_data_q.pop_front();
    endtask

    task automatic clear_writes();
        write_addr_q.delete();
        write_data_q.delete();
    endtask

endmodule

// File: sim/tb_vm16_core.sv
// testbench for the vm16 core, loads small programs and checks the APB traffic they cause
// run with the sources in files.f, tb_vm16_core is the top
`timescale 1ns/1ps

module tb_vm16_core;

    localparam int INSTR_DEPTH    = vm16_pkg::INSTR_DEPTH_DEFAULT;
    localparam int PC_W           = $clog2(INSTR_DEPTH);
    localparam int TIMEOUT_CYCLES = 1000;

    logic             clk;
    logic             reset;
    logic             prog_we;
    logic [PC_W-1:0]  prog_addr;
    vm16_pkg::instr_t prog_data;
    vm16_pkg::word_t  paddr;
    logic             pwrite;
    logic             psel;
    logic             penable;
    vm16_pkg::word_t  pwdata;
    vm16_pkg::word_t  prdata;
    logic             pready;
    logic [PC_W-1:0]  pc;
    logic             halted;
    logic [1:0]       wait_states;
    logic [31:0]      lfsr_state;
    int               setup_count;
    vm16_pkg::instr_t program_q [$];

    vm16_core #(
        .INSTR_DEPTH(INSTR_DEPTH),
        .SCRATCH_DEPTH(vm16_pkg::SCRATCH_DEPTH_DEFAULT)
    ) uut (
        .clk(clk), .reset(reset),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pc(pc), .halted(halted)
    );

    tb_apb_slave slave_model (
        .clk(clk), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .wait_states(wait_states), .prdata(prdata), .pready(pready)
    );

    always #5 clk = ~clk;

    // one setup cycle per APB transfer
    always @(posedge clk) begin
        if (psel && !penable) begin
            setup_count++;
        end
    end

    // new wait count once a transfer completes
    always @(posedge clk) begin
        if (psel && penable && pready) begin
            #1;
            wait_states = 2'(random_bits(2));
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string test, input string what,
                              input vm16_pkg::word_t expected, input vm16_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Error in %s: %s expected 0x%h, actual 0x%h", test, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string test, input string what,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error in %s: %s expected %b, actual %b", test, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_pc(input string test, input logic [PC_W-1:0] expected,
                            input logic [PC_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error in %s: pc expected %0d, actual %0d", test, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_transfers(input string test, input int expected);
        if (setup_count != expected) begin
            $display("Error in %s: APB transfers expected %0d, actual %0d",
                     test, expected, setup_count);
            stop_on_failure();
        end
    endtask

    task automatic expect_write(input string test, input vm16_pkg::word_t addr,
                                input vm16_pkg::word_t data);
        vm16_pkg::word_t got_addr;
        vm16_pkg::word_t got_data;
        if (slave_model.write_count() == 0) begin
            $display("%s: expected an APB write to 0x%h but none was recorded", test, addr);
            stop_on_failure();
        end else begin
            slave_model.pop_write(got_addr, got_data);
            check_word(test, "write address", addr, got_addr);
            check_word(test, "write data", data, got_data);
        end
    endtask

    task automatic expect_no_more_writes(input string test);
        if (slave_model.write_count() != 0) begin
            $display("%s: %0d APB writes more than expected", test, slave_model.write_count());
            stop_on_failure();
        end
    endtask

    // register form: opcode, rd, ra, function or offset
    task automatic emit_rr(input vm16_pkg::opcode_t op, input int rd, input int ra,
                           input vm16_pkg::funct_t fn);
        program_q.push_back({op, 3'(rd), 3'(ra), fn});
    endtask

    task automatic emit_imm(input vm16_pkg::opcode_t op, input int rd, input logic [7:0] imm);
        program_q.push_back({op, 3'(rd), imm});
    endtask

    task automatic emit_halt();
        emit_rr(vm16_pkg::OP_HALT, 0, 0, 5'd0);
    endtask

    // reset stays high while the program is written, then two more cycles
    task automatic load_program();
        @(posedge clk);
        #1;
        reset = 1'b1;
        slave_model.clear_writes();
        setup_count = 0;
        foreach (program_q[i]) begin
            prog_we   = 1'b1;
            prog_addr = PC_W'(i);
            prog_data = program_q[i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic wait_for_halt(input string test);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("%s: core did not halt within %0d cycles", test, TIMEOUT_CYCLES);
            stop_on_failure();
        end
    endtask

    task automatic reset_state_test();
        program_q.delete();
        emit_imm(vm16_pkg::OP_MOVI, 0, 8'hc0);
        emit_rr(vm16_pkg::OP_SW, 3, 0, 5'd0);
        emit_rr(vm16_pkg::OP_SW, 5, 0, 5'd1);
        emit_halt();
        load_program();
        check_bit("reset_state", "psel", 1'b0, psel);
        check_bit("reset_state", "penable", 1'b0, penable);
        check_bit("reset_state", "pwrite", 1'b0, pwrite);
        check_bit("reset_state", "halted", 1'b0, halted);
        check_pc("reset_state", '0, pc);
        wait_for_halt("reset_state");
        // registers come out of reset holding their own index
        expect_write("reset_state", 16'h00c0, 16'd3);
        expect_write("reset_state", 16'h00c1, 16'd5);
        expect_no_more_writes("reset_state");
    endtask

    // copy a into r4, apply the op, store r4 to slot
    task automatic emit_alu_step(input vm16_pkg::funct_t fn, input vm16_pkg::opcode_t op,
                                 input int src, input int slot);
        emit_rr(vm16_pkg::OP_MOV, 4, 1, 5'd0);
        emit_rr(op, 4, src, fn);
        emit_rr(vm16_pkg::OP_SW, 4, 0, 5'(slot));
    endtask

    task automatic alu_ops_test();
        vm16_pkg::word_t a;
        vm16_pkg::word_t b;
        vm16_pkg::word_t s;
        vm16_pkg::word_t expected [9];
        // top bit of a set and an odd shift below 8, so no shift result is zero
        a = random_bits(8) | 16'h0080;
        b = random_bits(8);
        s = random_bits(3) | 16'h0001;
        expected[0] = a | b;
        expected[1] = a ^ b;
        expected[2] = a & b;
        expected[3] = ~b;
        expected[4] = a << s;
        expected[5] = a >> s;
        expected[6] = a + b;
        expected[7] = a - b;
        expected[8] = b;
        program_q.delete();
        emit_imm(vm16_pkg::OP_MOVI, 1, a[7:0]);
        emit_imm(vm16_pkg::OP_MOVI, 2, b[7:0]);
        emit_imm(vm16_pkg::OP_MOVI, 3, s[7:0]);
        emit_imm(vm16_pkg::OP_MOVI, 0, 8'hc0);
        emit_alu_step(vm16_pkg::FN_OR, vm16_pkg::OP_BIT, 2, 0);
        emit_alu_step(vm16_pkg::FN_XOR, vm16_pkg::OP_BIT, 2, 1);
        emit_alu_step(vm16_pkg::FN_AND, vm16_pkg::OP_BIT, 2, 2);
        emit_alu_step(vm16_pkg::FN_NOT, vm16_pkg::OP_BIT, 2, 3);
        emit_alu_step(vm16_pkg::FN_LSHIFT, vm16_pkg::OP_BIT, 3, 4);
        emit_alu_step(vm16_pkg::FN_RSHIFT, vm16_pkg::OP_BIT, 3, 5);
        emit_alu_step(vm16_pkg::FN_ADD, vm16_pkg::OP_ARITH_U, 2, 6);
        emit_alu_step(vm16_pkg::FN_SUB, vm16_pkg::OP_ARITH_U, 2, 7);
        emit_rr(vm16_pkg::OP_MOV, 4, 2, 5'd0);
        emit_rr(vm16_pkg::OP_SW, 4, 0, 5'd8);
        emit_halt();
        load_program();
        wait_for_halt("alu_ops");
        for (int k = 0; k < 9; k++) begin
            expect_write("alu_ops", 16'h00c0 + vm16_pkg::word_t'(k), expected[k]);
        end
        expect_no_more_writes("alu_ops");
    endtask

    task automatic scratch_memory_test();
        logic [7:0] v;
        v = 8'(random_bits(8));
        program_q.delete();
        // r0 is still 0 from reset, so [r0+5] is scratch word 5
        emit_imm(vm16_pkg::OP_MOVI, 1, v);
        emit_rr(vm16_pkg::OP_SW, 1, 0, 5'd5);
        emit_imm(vm16_pkg::OP_MOVI, 1, ~v);
        emit_rr(vm16_pkg::OP_LW, 1, 0, 5'd5);
        emit_imm(vm16_pkg::OP_MOVI, 2, 8'hc0);
        emit_rr(vm16_pkg::OP_SW, 1, 2, 5'd0);
        emit_halt();
        load_program();
        wait_for_halt("scratch_memory");
        check_transfers("scratch_memory", 1);
        expect_write("scratch_memory", 16'h00c0, {8'h00, v});
        expect_no_more_writes("scratch_memory");
    endtask

    task automatic apb_load_test();
        vm16_pkg::word_t data;
        data = random_bits(16);
        slave_model.set_read_word(16'h0090, data);
        program_q.delete();
        emit_imm(vm16_pkg::OP_MOVI, 1, 8'h90);
        emit_rr(vm16_pkg::OP_LW, 2, 1, 5'd0);
        emit_imm(vm16_pkg::OP_MOVI, 3, 8'hc0);
        emit_rr(vm16_pkg::OP_SW, 2, 3, 5'd0);
        emit_halt();
        load_program();
        wait_for_halt("apb_load");
        check_transfers("apb_load", 2);
        expect_write("apb_load", 16'h00c0, data);
        expect_no_more_writes("apb_load");
    endtask

    task automatic halt_test();
        int              halt_addr;
        vm16_pkg::word_t paddr_seen;
        vm16_pkg::word_t pwdata_seen;
        logic            pwrite_seen;
        program_q.delete();
        emit_imm(vm16_pkg::OP_MOVI, 1, 8'h5a);
        emit_imm(vm16_pkg::OP_MOVI, 2, 8'hc4);
        emit_rr(vm16_pkg::OP_SW, 1, 2, 5'd0);
        emit_halt();
        halt_addr = program_q.size() - 1;
        // must never execute
        emit_rr(vm16_pkg::OP_SW, 1, 2, 5'd1);
        load_program();
        wait_for_halt("halt");
        check_pc("halt", PC_W'(halt_addr + 1), pc);
        paddr_seen  = paddr;
        pwdata_seen = pwdata;
        pwrite_seen = pwrite;
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit("halt", "halted", 1'b1, halted);
            check_pc("halt", PC_W'(halt_addr + 1), pc);
            check_bit("halt", "psel", 1'b0, psel);
            check_bit("halt", "penable", 1'b0, penable);
            check_bit("halt", "pwrite", pwrite_seen, pwrite);
            check_word("halt", "paddr", paddr_seen, paddr);
            check_word("halt", "pwdata", pwdata_seen, pwdata);
        end
        expect_write("halt", 16'h00c4, 16'h005a);
        expect_no_more_writes("halt");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        setup_count = 0;
        lfsr_state  = 32'h802d1d23;
        wait_states = 2'(random_bits(2));
        reset_state_test();
        alu_ops_test();
        scratch_memory_test();
        apb_load_test();
        halt_test();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: files.f
common/vm16_pkg.sv
common/vm16_mem_if.sv
design/vm16_bram.sv
core/vm16_decoder.sv
core/vm16_alu.sv
core/vm16_regfile.sv
core/vm16_pc.sv
core/vm16_control.sv
mmu/vm16_mmu.sv
core/vm16_core.sv
sim/tb_apb_slave.sv
sim/tb_vm16_core.sv

// File: Bender.yml
package:
  name: vm16_core

sources:
  - common/vm16_pkg.sv
  - common/vm16_mem_if.sv
  - design/vm16_bram.sv
  - core/vm16_decoder.sv
  - core/vm16_alu.sv
  - core/vm16_regfile.sv
  - core/vm16_pc.sv
  - core/vm16_control.sv
  - mmu/vm16_mmu.sv
  - core/vm16_core.sv
  - target: simulation
    files:
      - sim/tb_apb_slave.sv
      - sim/tb_vm16_core.sv
